//--- files.f
src/hmc_flit_pkg.sv
src/hmc_req_gen.sv
src/hmc_rx_fifo.sv
src/hmc_rsp_decode.sv
src/hmc_flit_user.sv
test/hmc_flit_user_tb.sv

//--- Bender.yml
package:
  name: hmc_flit_user

sources:
  - src/hmc_flit_pkg.sv
  - src/hmc_req_gen.sv
  - src/hmc_rx_fifo.sv
  - src/hmc_rsp_decode.sv
  - src/hmc_flit_user.sv
  - target: test
    files:
      - test/hmc_flit_user_tb.sv

//--- test/hmc_flit_user_tb.sv
// ----------------------------------------
// Testbench for the HMC link user engine
// Drives requests and RX response words, checks TX words and decoded responses
// ----------------------------------------
`timescale 1ns/1ps

module hmc_flit_user_tb;

  localparam int TMO = 600;
  // Read response command as the link returns it
  localparam logic [5:0] CMD_RD_RS = 6'b111000;

  logic CLK, RST, post_done_i;
  logic s_axis_tx_tvalid_o, s_axis_tx_tready_i, req_ready_o;
  logic [hmc_flit_pkg::DWIDTH-1:0] s_axis_tx_tdata_o, m_axis_rx_tdata_i;
  logic [hmc_flit_pkg::TUSER_W-1:0] s_axis_tx_tuser_o, m_axis_rx_tuser_i;
  logic m_axis_rx_tvalid_i, m_axis_rx_tready_o, wr_req_i, rd_req_i, data_valid_o;
  logic [hmc_flit_pkg::ADDR_W-1:0] wr_address_i, rd_address_i;
  logic [hmc_flit_pkg::DATA_W-1:0] data_in_i, data_out_o;
  logic [hmc_flit_pkg::TAG_W-1:0] tag_in_i, tag_out_o;

  logic [31:0] seed;
  int errors, cyc, pd_cnt, last_dv, n_rsp, n_tx;
  bit saw_full;
  // Expected TX words and responses in arrival order
  logic [hmc_flit_pkg::DWIDTH-1:0] tx_data_q[$];
  logic [hmc_flit_pkg::TUSER_W-1:0] tx_user_q[$];
  logic [hmc_flit_pkg::TAG_W-1:0] rsp_tag_q[$];
  logic [hmc_flit_pkg::DATA_W-1:0] rsp_data_q[$];
  // Set when the response must follow the previous one on the next cycle
  bit rsp_next_q[$];
  // Two-word window for laying response FLITs onto the RX stream
  logic [2*hmc_flit_pkg::DWIDTH-1:0] win_data;
  logic [2*hmc_flit_pkg::FPW-1:0] win_v, win_h, win_t;

  hmc_flit_user dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (post_done_i) begin
      pd_cnt <= pd_cnt + 1;
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [hmc_flit_pkg::DATA_W-1:0] rand_payload();
    logic [hmc_flit_pkg::DATA_W-1:0] d;
    for (int i = 0; i < hmc_flit_pkg::DATA_W / 32; i++) begin
      d[i*32 +: 32] = next_rand();
    end
    return d;
  endfunction

  // Header word with the address given in 32-byte units
  function automatic logic [63:0] header(input logic [5:0] cmd, input logic [3:0] len,
                                         input logic [8:0] tag, input logic [26:0] unit);
    logic [63:0] h;
    h = '0;
    h[hmc_flit_pkg::CMD_LO +: 6]    = cmd;
    h[hmc_flit_pkg::LNG_LO +: 4]    = len;
    h[hmc_flit_pkg::DLN_LO +: 4]    = len;
    h[hmc_flit_pkg::TAG_LO +: 9]    = tag;
    h[hmc_flit_pkg::HADDR_LO +: 34] = {2'b00, unit, 5'b00000};
    return h;
  endfunction

  // Wait until every expected TX word and response has been seen
  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((tx_data_q.size() != 0 || rsp_tag_q.size() != 0) && n < limit) begin
      @(negedge CLK);
      n++;
    end
    assert (tx_data_q.size() == 0 && rsp_tag_q.size() == 0) else begin
      errors++;
      $display("Timeout with %0d TX words and %0d responses still missing",
               tx_data_q.size(), rsp_tag_q.size());
    end
    // Quiet cycles where a stray pulse would show
    repeat (3) @(negedge CLK);
  endtask

  // One requesting cycle and the TX word it should produce
  task automatic request(input bit wr, input bit rd);
    logic [hmc_flit_pkg::DWIDTH-1:0] w;
    logic [hmc_flit_pkg::TUSER_W-1:0] u;
    logic [31:0] r;
    w = '0;
    u = '0;
    r = next_rand();
    wr_address_i = r[26:0];
    r = next_rand();
    rd_address_i = r[26:0];
    r = next_rand();
    tag_in_i = r[8:0];
    data_in_i = rand_payload();
    if (wr) begin
      w[0 +: 64] = header(hmc_flit_pkg::CMD_P_WR32, hmc_flit_pkg::LEN_P_WR32,
                          hmc_flit_pkg::WR_TAG, wr_address_i);
      // Payload runs from FLIT 0 upper half to FLIT 2 lower half
      w[64 +: 256] = data_in_i;
      u[2:0] = 3'b111;
      u[6:4] = 3'b001;
      u[10:8] = 3'b100;
    end
    if (rd) begin
      w[384 +: 64] = header(hmc_flit_pkg::CMD_RD32, hmc_flit_pkg::LEN_RD32,
                            tag_in_i, rd_address_i);
      u[3] = 1'b1;
      u[7] = 1'b1;
      u[11] = 1'b1;
    end
    tx_data_q.push_back(w);
    tx_user_q.push_back(u);
    assert (req_ready_o) else begin
      errors++;
      $display("Fail %0t req_ready_o got %b expected 1", $time, req_ready_o);
    end
    wr_req_i = wr;
    rd_req_i = rd;
    @(negedge CLK);
    wr_req_i = 1'b0;
    rd_req_i = 1'b0;
    wait_drain(20);
  endtask

  // Lay a three-FLIT read response into the window from FLIT slot s
  task automatic place_rsp(input int s, input bit adj);
    logic [383:0] pkt;
    logic [hmc_flit_pkg::DATA_W-1:0] d;
    logic [31:0] r;
    r = next_rand();
    d = rand_payload();
    // Tail CRC field filled with noise
    pkt = {r, r, d, header(CMD_RD_RS, 4'd3, r[8:0], 27'd0)};
    win_data[s*128 +: 384] = pkt;
    win_v[s +: 3] = 3'b111;
    win_h[s] = 1'b1;
    win_t[s+2] = 1'b1;
    rsp_tag_q.push_back(r[8:0]);
    rsp_data_q.push_back(d);
    rsp_next_q.push_back(adj);
  endtask

  // Send the lower window word, then slide the upper one down
  task automatic ship_word();
    int n;
    m_axis_rx_tvalid_i = 1'b1;
    m_axis_rx_tdata_i = win_data[hmc_flit_pkg::DWIDTH-1:0];
    m_axis_rx_tuser_i = {win_t[3:0], win_h[3:0], win_v[3:0]};
    n = 0;
    while (!m_axis_rx_tready_o && n < TMO) begin
      saw_full = 1'b1;
      @(negedge CLK);
      n++;
    end
    assert (m_axis_rx_tready_o) else begin
      errors++;
      $display("Timeout, RX word never accepted by the FIFO");
    end
    @(negedge CLK);
    m_axis_rx_tvalid_i = 1'b0;
    win_data = win_data >> hmc_flit_pkg::DWIDTH;
    win_v = win_v >> hmc_flit_pkg::FPW;
    win_h = win_h >> hmc_flit_pkg::FPW;
    win_t = win_t >> hmc_flit_pkg::FPW;
  endtask

  // ----------------------------------------
  // Checkers
  // ----------------------------------------
  // Nothing leaves the engine during the hold-off
  holdoff_quiet: assert property (@(posedge CLK) disable iff (RST)
      (pd_cnt < 256) |-> (!s_axis_tx_tvalid_o && !req_ready_o))
    else begin
      errors++;
      $display("Fail %0t s_axis_tx_tvalid_o/req_ready_o got %b/%b expected 0/0", $time,
               $sampled(s_axis_tx_tvalid_o), $sampled(req_ready_o));
    end

  // Ready mirrors last cycle's TREADY
  ready_follows: assert property (@(posedge CLK) disable iff (RST)
      req_ready_o |-> $past(s_axis_tx_tready_i))
    else begin
      errors++;
      $display("Fail %0t req_ready_o got 1 expected 0", $time);
    end

  always @(negedge CLK) begin
    if (!RST && s_axis_tx_tvalid_o) begin
      n_tx++;
      assert (tx_data_q.size() != 0) else begin
        errors++;
        $display("TX valid pulse at %0t with no request outstanding", $time);
      end
      if (tx_data_q.size() != 0) begin
        assert (s_axis_tx_tdata_o == tx_data_q[0]) else begin
          errors++;
          $display("Fail %0t s_axis_tx_tdata_o got %h expected %h", $time,
                   s_axis_tx_tdata_o, tx_data_q[0]);
        end
        assert (s_axis_tx_tuser_o == tx_user_q[0]) else begin
          errors++;
          $display("Fail %0t s_axis_tx_tuser_o got %h expected %h", $time,
                   s_axis_tx_tuser_o, tx_user_q[0]);
        end
        void'(tx_data_q.pop_front());
        void'(tx_user_q.pop_front());
      end
    end
    if (!RST && data_valid_o) begin
      n_rsp++;
      assert (rsp_tag_q.size() != 0) else begin
        errors++;
        $display("Response with tag %h at %0t when none was expected", tag_out_o, $time);
      end
      if (rsp_tag_q.size() != 0) begin
        assert (tag_out_o == rsp_tag_q[0]) else begin
          errors++;
          $display("Fail %0t tag_out_o got %h expected %h", $time, tag_out_o, rsp_tag_q[0]);
        end
        assert (data_out_o == rsp_data_q[0]) else begin
          errors++;
          $display("Fail %0t data_out_o got %h expected %h", $time,
                   data_out_o, rsp_data_q[0]);
        end
        assert (!rsp_next_q[0] || cyc == last_dv + 1) else begin
          errors++;
          $display("Held response at %0t did not follow the first one directly", $time);
        end
        void'(rsp_tag_q.pop_front());
        void'(rsp_data_q.pop_front());
        void'(rsp_next_q.pop_front());
      end
      last_dv = cyc;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int n;
    seed = 32'ha247;
    RST = 1'b1;
    post_done_i = 1'b0;
    // Link ready from the start, only the hold-off keeps requests back
    s_axis_tx_tready_i = 1'b1;
    m_axis_rx_tvalid_i = 1'b0;
    m_axis_rx_tdata_i = '0;
    m_axis_rx_tuser_i = '0;
    wr_address_i = '0;
    data_in_i = '0;
    wr_req_i = 1'b0;
    rd_address_i = '0;
    tag_in_i = '0;
    rd_req_i = 1'b0;
    win_data = '0;
    win_v = '0;
    win_h = '0;
    win_t = '0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    assert (!s_axis_tx_tvalid_o && s_axis_tx_tuser_o == '0 && !req_ready_o && !data_valid_o)
      else begin
        errors++;
        $display("Fail %0t tvalid/tuser/req_ready_o/data_valid_o got %b/%h/%b/%b expected 0",
                 $time, s_axis_tx_tvalid_o, s_axis_tx_tuser_o, req_ready_o, data_valid_o);
      end

    // Burst of 36 words into an idle decoder fills the FIFO
    fork
      begin
        for (int i = 0; i < 36; i++) begin
          place_rsp(i % 2, 1'b0);
          ship_word();
        end
      end
      begin
        n = 0;
        while (!saw_full && n < TMO) begin
          @(negedge CLK);
          n++;
        end
        assert (saw_full) else begin
          errors++;
          $display("m_axis_rx_tready_o never dropped during the burst");
        end
        repeat (4) @(negedge CLK);
        post_done_i = 1'b1;
      end
    join
    wait_drain(TMO);

    // Hold-off ends, then one cycle in the wait state and one for the ready register
    n = 0;
    while (!req_ready_o && n < TMO) begin
      @(negedge CLK);
      n++;
    end
    assert (req_ready_o && pd_cnt <= 260) else begin
      errors++;
      $display("req_ready_o did not rise within a few cycles after the hold-off");
    end

    // Write alone, read alone, then both in one word
    request(1'b1, 1'b0);
    request(1'b0, 1'b1);
    request(1'b1, 1'b1);

    // TREADY drop shows on req_ready_o one edge later
    s_axis_tx_tready_i = 1'b0;
    @(negedge CLK);
    s_axis_tx_tready_i = 1'b1;
    assert (!req_ready_o) else begin
      errors++;
      $display("Fail %0t req_ready_o got %b expected 0", $time, req_ready_o);
    end
    @(negedge CLK);
    assert (req_ready_o) else begin
      errors++;
      $display("Fail %0t req_ready_o got %b expected 1", $time, req_ready_o);
    end

    // Alignments A and B
    place_rsp(0, 1'b0);
    ship_word();
    place_rsp(1, 1'b0);
    ship_word();
    // C and D straddle a word boundary
    place_rsp(2, 1'b0);
    ship_word();
    ship_word();
    place_rsp(3, 1'b0);
    ship_word();
    ship_word();
    // C finishing in the same word as a whole B response
    place_rsp(2, 1'b0);
    ship_word();
    place_rsp(1, 1'b1);
    ship_word();
    // D finishing next to a C start
    place_rsp(3, 1'b0);
    ship_word();
    place_rsp(2, 1'b0);
    ship_word();
    ship_word();
    wait_drain(TMO);

    $display("Errors: %0d, TX words: %0d, responses: %0d", errors, n_tx, n_rsp);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src/hmc_flit_user.sv
// ----------------------------------------
// HMC link user engine, request generator, RX FIFO and decoder
// ----------------------------------------
`timescale 1ns/1ps

module hmc_flit_user (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              post_done_i,
  // TX stream to the controller
  output logic                              s_axis_tx_tvalid_o,
  input  logic                              s_axis_tx_tready_i,
  output logic [hmc_flit_pkg::DWIDTH-1:0]   s_axis_tx_tdata_o,
  output logic [hmc_flit_pkg::TUSER_W-1:0]  s_axis_tx_tuser_o,
  // RX stream from the controller
  input  logic                              m_axis_rx_tvalid_i,
  output logic                              m_axis_rx_tready_o,
  input  logic [hmc_flit_pkg::DWIDTH-1:0]   m_axis_rx_tdata_i,
  input  logic [hmc_flit_pkg::TUSER_W-1:0]  m_axis_rx_tuser_i,
  // User write and read requests
  input  logic [hmc_flit_pkg::ADDR_W-1:0]   wr_address_i,
  input  logic [hmc_flit_pkg::DATA_W-1:0]   data_in_i,
  input  logic                              wr_req_i,
  input  logic [hmc_flit_pkg::ADDR_W-1:0]   rd_address_i,
  input  logic [hmc_flit_pkg::TAG_W-1:0]    tag_in_i,
  input  logic                              rd_req_i,
  output logic                              req_ready_o,
  // Read responses
  output logic [hmc_flit_pkg::DATA_W-1:0]   data_out_o,
  output logic [hmc_flit_pkg::TAG_W-1:0]    tag_out_o,
  output logic                              data_valid_o
);

  logic                              rx_valid;
  logic [hmc_flit_pkg::DWIDTH-1:0]   rx_data;
  logic [hmc_flit_pkg::TUSER_W-1:0]  rx_flags;
  logic                              rx_pop;

  hmc_req_gen u_req_gen (
    .CLK                (CLK),
    .RST                (RST),
    .post_done_i        (post_done_i),
    .s_axis_tx_tready_i (s_axis_tx_tready_i),
    .wr_address_i       (wr_address_i),
    .data_in_i          (data_in_i),
    .wr_req_i           (wr_req_i),
    .rd_address_i       (rd_address_i),
    .tag_in_i           (tag_in_i),
    .rd_req_i           (rd_req_i),
    .s_axis_tx_tvalid_o (s_axis_tx_tvalid_o),
    .s_axis_tx_tdata_o  (s_axis_tx_tdata_o),
    .s_axis_tx_tuser_o  (s_axis_tx_tuser_o),
    .req_ready_o        (req_ready_o)
  );

  // RX words buffered so the decoder can pause for double responses
  hmc_rx_fifo u_rx_fifo (
    .CLK         (CLK),
    .RST         (RST),
    .in_valid_i  (m_axis_rx_tvalid_i),
    .in_data_i   (m_axis_rx_tdata_i),
    .in_flags_i  (m_axis_rx_tuser_i),
    .pop_i       (rx_pop),
    .in_ready_o  (m_axis_rx_tready_o),
    .out_valid_o (rx_valid),
    .out_data_o  (rx_data),
    .out_flags_o (rx_flags)
  );

  hmc_rsp_decode u_rsp_decode (
    .CLK          (CLK),
    .RST          (RST),
    .post_done_i  (post_done_i),
    .rx_valid_i   (rx_valid),
    .rx_data_i    (rx_data),
    .rx_flags_i   (rx_flags),
    .rx_pop_o     (rx_pop),
    .data_out_o   (data_out_o),
    .tag_out_o    (tag_out_o),
    .data_valid_o (data_valid_o)
  );

endmodule

//--- src/hmc_rsp_decode.sv
// ----------------------------------------
// Rebuilds 32-byte read responses from RX words
// Handles all four FLIT alignments and two responses in one word
// ----------------------------------------
`timescale 1ns/1ps

module hmc_rsp_decode (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              post_done_i,
  input  logic                              rx_valid_i,
  input  logic [hmc_flit_pkg::DWIDTH-1:0]   rx_data_i,
  input  logic [hmc_flit_pkg::TUSER_W-1:0]  rx_flags_i,
  output logic                              rx_pop_o,
  output logic [hmc_flit_pkg::DATA_W-1:0]   data_out_o,
  output logic [hmc_flit_pkg::TAG_W-1:0]    tag_out_o,
  output logic                              data_valid_o
);

  logic                                   run_q;
  logic                                   take;
  logic [hmc_flit_pkg::FPW-1:0]           v;
  logic [hmc_flit_pkg::FPW-1:0]           h;
  logic [hmc_flit_pkg::FPW-1:0]           t;
  hmc_flit_pkg::flit_t                    fl [hmc_flit_pkg::FPW];
  logic                                   a_hit;
  logic                                   b_hit;
  logic                                   c_start;
  logic                                   d_start;
  logic                                   c_fin;
  logic                                   d_fin;
  logic                                   dbl;
  logic [hmc_flit_pkg::DATA_W-1:0]        b_data;
  // Partial response waiting for its last FLITs
  logic                                   pend_c_q;
  logic                                   pend_d_q;
  logic [hmc_flit_pkg::TAG_W-1:0]         pend_tag_q;
  logic [hmc_flit_pkg::DATA_W-hmc_flit_pkg::TAIL_W-1:0] pend_data_q;
  // Second response of a double word
  logic                                   hold_v_q;
  logic [hmc_flit_pkg::TAG_W-1:0]         hold_tag_q;
  logic [hmc_flit_pkg::DATA_W-1:0]        hold_data_q;
  logic                                   emit;
  logic [hmc_flit_pkg::TAG_W-1:0]         emit_tag;
  logic [hmc_flit_pkg::DATA_W-1:0]        emit_data;

  // A word is consumed when the FIFO has one and we pop
  assign take = rx_valid_i & rx_pop_o;
  assign v    = rx_flags_i[hmc_flit_pkg::FLG_VALID +: hmc_flit_pkg::FPW];
  assign h    = rx_flags_i[hmc_flit_pkg::FLG_HDR +: hmc_flit_pkg::FPW];
  assign t    = rx_flags_i[hmc_flit_pkg::FLG_TAIL +: hmc_flit_pkg::FPW];

  always_comb begin
    for (int i = 0; i < hmc_flit_pkg::FPW; i++) begin
      fl[i].raw = rx_data_i[i*hmc_flit_pkg::FLIT_W +: hmc_flit_pkg::FLIT_W];
    end
  end

  // ----------------------------------------
  // Flag patterns per alignment
  // ----------------------------------------
  // Whole response in FLITs 0 to 2 or 1 to 3
  assign a_hit   = take && t[2:0] == 3'b100 && h[2:0] == 3'b001 && v[2:0] == 3'b111;
  assign b_hit   = take && t[3:1] == 3'b100 && h[3:1] == 3'b001 && v[3:1] == 3'b111;
  // Header in FLIT 2 or FLIT 3, tail in the next word
  assign c_start = take && t[3:2] == 2'b00 && h[3:2] == 2'b01 && v[3:2] == 2'b11;
  assign d_start = take && !t[3] && h[3] && v[3];
  assign c_fin   = take && pend_c_q && t[0] && !h[0] && v[0];
  assign d_fin   = take && pend_d_q && t[1:0] == 2'b10 && h[1:0] == 2'b00
                   && v[1:0] == 2'b11;
  // C tail in FLIT 0 with a full B response behind it
  assign dbl     = c_fin && b_hit;

  assign b_data = rx_data_i[hmc_flit_pkg::FLIT_W + hmc_flit_pkg::HDR_W +: hmc_flit_pkg::DATA_W];

  // Pick the response completed by this word, oldest first
  always_comb begin
    emit      = 1'b1;
    emit_tag  = pend_tag_q;
    emit_data = {rx_data_i[0 +: hmc_flit_pkg::TAIL_W], pend_data_q};
    if (c_fin) begin
      emit_tag = pend_tag_q;
    end else if (d_fin) begin
      emit_data = {rx_data_i[0 +: hmc_flit_pkg::DATA_W - hmc_flit_pkg::TAIL_W],
                   pend_data_q[hmc_flit_pkg::TAIL_W-1:0]};
    end else if (b_hit) begin
      emit_tag  = fl[1].hv.hdr.tag;
      emit_data = b_data;
    end else if (a_hit) begin
      emit_tag  = fl[0].hv.hdr.tag;
      emit_data = rx_data_i[hmc_flit_pkg::HDR_W +: hmc_flit_pkg::DATA_W];
    end else begin
      emit = 1'b0;
    end
  end

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      run_q        <= 1'b0;
      rx_pop_o     <= 1'b0;
      pend_c_q     <= 1'b0;
      pend_d_q     <= 1'b0;
      hold_v_q     <= 1'b0;
      data_valid_o <= 1'b0;
    end else begin
      run_q <= run_q | post_done_i;
      // Skip one pop so the held response gets its own cycle
      rx_pop_o     <= (run_q | post_done_i) & ~dbl;
      pend_c_q     <= c_start | (pend_c_q & ~c_fin);
      pend_d_q     <= d_start | (pend_d_q & ~d_fin);
      hold_v_q     <= dbl;
      data_valid_o <= emit | hold_v_q;
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (hold_v_q) begin
      data_out_o <= hold_data_q;
      tag_out_o  <= hold_tag_q;
    end else if (emit) begin
      data_out_o <= emit_data;
      tag_out_o  <= emit_tag;
    end
    if (dbl) begin
      hold_tag_q  <= fl[1].hv.hdr.tag;
      hold_data_q <= b_data;
    end
    // C keeps 192 payload bits, D only 64
    if (c_start) begin
      pend_tag_q  <= fl[2].hv.hdr.tag;
      pend_data_q <= rx_data_i[2*hmc_flit_pkg::FLIT_W + hmc_flit_pkg::HDR_W
                               +: hmc_flit_pkg::DATA_W - hmc_flit_pkg::TAIL_W];
    end else if (d_start) begin
      pend_tag_q <= fl[3].hv.hdr.tag;
      pend_data_q[hmc_flit_pkg::TAIL_W-1:0] <=
        rx_data_i[3*hmc_flit_pkg::FLIT_W + hmc_flit_pkg::HDR_W +: hmc_flit_pkg::TAIL_W];
    end
  end

endmodule

//--- src/hmc_rx_fifo.sv
// ----------------------------------------
// 32-deep FIFO for RX words and FLIT flags
// ----------------------------------------
`timescale 1ns/1ps

module hmc_rx_fifo (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              in_valid_i,
  input  logic [hmc_flit_pkg::DWIDTH-1:0]   in_data_i,
  input  logic [hmc_flit_pkg::TUSER_W-1:0]  in_flags_i,
  input  logic                              pop_i,
  output logic                              in_ready_o,
  output logic                              out_valid_o,
  output logic [hmc_flit_pkg::DWIDTH-1:0]   out_data_o,
  output logic [hmc_flit_pkg::TUSER_W-1:0]  out_flags_o
);

  // Flags stored above the data
  logic [hmc_flit_pkg::TUSER_W+hmc_flit_pkg::DWIDTH-1:0] mem_q [hmc_flit_pkg::RX_FIFO_DEPTH];
  logic [hmc_flit_pkg::RX_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [hmc_flit_pkg::RX_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [hmc_flit_pkg::RX_FIFO_PTR_W:0]   count_q;
  logic                                   push;
  logic                                   pop;

  assign in_ready_o  = (count_q != hmc_flit_pkg::RX_FIFO_DEPTH);
  assign out_valid_o = (count_q != '0);
  assign push        = in_valid_i & in_ready_o;
  assign pop         = pop_i & out_valid_o;

  // Oldest word shown straight from the array
  assign {out_flags_o, out_data_o} = mem_q[rd_ptr_q];

  always_ff @(posedge CLK) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {in_flags_i, in_data_i};
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Depth is a power of two so pointers wrap on their own
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- src/hmc_req_gen.sv
// ----------------------------------------
// Start-up hold-off and TX request packing
// Posted write in FLITs 0 to 2, read in FLIT 3
// ----------------------------------------
`timescale 1ns/1ps

module hmc_req_gen (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                post_done_i,
  input  logic                                s_axis_tx_tready_i,
  input  logic [hmc_flit_pkg::ADDR_W-1:0]     wr_address_i,
  input  logic [hmc_flit_pkg::DATA_W-1:0]     data_in_i,
  input  logic                                wr_req_i,
  input  logic [hmc_flit_pkg::ADDR_W-1:0]     rd_address_i,
  input  logic [hmc_flit_pkg::TAG_W-1:0]      tag_in_i,
  input  logic                                rd_req_i,
  output logic                                s_axis_tx_tvalid_o,
  output logic [hmc_flit_pkg::DWIDTH-1:0]     s_axis_tx_tdata_o,
  output logic [hmc_flit_pkg::TUSER_W-1:0]    s_axis_tx_tuser_o,
  output logic                                req_ready_o
);

  logic [1:0]                             state_q;
  logic [hmc_flit_pkg::HOLDOFF_W-1:0]     holdoff_q;
  logic                                   wr_go;
  logic                                   rd_go;
  hmc_flit_pkg::flit_t                    wr_f0;
  hmc_flit_pkg::flit_t                    wr_f1;
  hmc_flit_pkg::flit_t                    wr_f2;
  hmc_flit_pkg::flit_t                    rd_f3;
  logic [hmc_flit_pkg::TUSER_W-1:0]       tuser_d;

  // 32-byte unit to cube address, top bits zero
  function automatic logic [hmc_flit_pkg::HADDR_W-1:0] hmc_addr(
    input logic [hmc_flit_pkg::ADDR_W-1:0] a
  );
    hmc_addr = {{(hmc_flit_pkg::HADDR_W - hmc_flit_pkg::ADDR_W
                  - hmc_flit_pkg::ADDR_SHIFT){1'b0}},
                a, {hmc_flit_pkg::ADDR_SHIFT{1'b0}}};
  endfunction

  // Requests only count in the request state
  assign wr_go = (state_q == hmc_flit_pkg::GEN_REQ) && wr_req_i;
  assign rd_go = (state_q == hmc_flit_pkg::GEN_REQ) && rd_req_i;

  always_comb begin
    wr_f0   = '0;
    wr_f1   = '0;
    wr_f2   = '0;
    rd_f3   = '0;
    tuser_d = '0;
    if (wr_go) begin
      wr_f0.hv.hdr.cmd  = hmc_flit_pkg::CMD_P_WR32;
      wr_f0.hv.hdr.lng  = hmc_flit_pkg::LEN_P_WR32;
      wr_f0.hv.hdr.dln  = hmc_flit_pkg::LEN_P_WR32;
      wr_f0.hv.hdr.tag  = hmc_flit_pkg::WR_TAG;
      wr_f0.hv.hdr.addr = hmc_addr(wr_address_i);
      // Payload fills FLIT 0 upper half, FLIT 1, FLIT 2 lower half
      wr_f0.hv.tail = data_in_i[0 +: hmc_flit_pkg::TAIL_W];
      wr_f1.raw     = data_in_i[hmc_flit_pkg::TAIL_W +: hmc_flit_pkg::FLIT_W];
      wr_f2.hv.hdr  = data_in_i[hmc_flit_pkg::TAIL_W + hmc_flit_pkg::FLIT_W
                                +: hmc_flit_pkg::HDR_W];
      // Valid 111, header 001, tail 100
      tuser_d[hmc_flit_pkg::FLG_VALID +: 3] = 3'b111;
      tuser_d[hmc_flit_pkg::FLG_HDR]        = 1'b1;
      tuser_d[hmc_flit_pkg::FLG_TAIL + 2]   = 1'b1;
    end
    if (rd_go) begin
      // Single FLIT read, tail left zero for the controller
      rd_f3.hv.hdr.cmd  = hmc_flit_pkg::CMD_RD32;
      rd_f3.hv.hdr.lng  = hmc_flit_pkg::LEN_RD32;
      rd_f3.hv.hdr.dln  = hmc_flit_pkg::LEN_RD32;
      rd_f3.hv.hdr.tag  = tag_in_i;
      rd_f3.hv.hdr.addr = hmc_addr(rd_address_i);
      tuser_d[hmc_flit_pkg::FLG_VALID + 3] = 1'b1;
      tuser_d[hmc_flit_pkg::FLG_HDR + 3]   = 1'b1;
      tuser_d[hmc_flit_pkg::FLG_TAIL + 3]  = 1'b1;
    end
  end

  // ----------------------------------------
  // Request FSM
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state_q            <= hmc_flit_pkg::GEN_IDLE;
      holdoff_q          <= '0;
      s_axis_tx_tvalid_o <= 1'b0;
      s_axis_tx_tuser_o  <= '0;
      req_ready_o        <= 1'b0;
    end else begin
      // One pulse per requesting cycle, TREADY not waited for
      s_axis_tx_tvalid_o <= wr_go | rd_go;
      s_axis_tx_tuser_o  <= tuser_d;
      req_ready_o        <= 1'b0;
      case (state_q)
        hmc_flit_pkg::GEN_IDLE: begin
          // Let the link finish its NULL FLITs first
          if (post_done_i) begin
            holdoff_q <= holdoff_q + 1'b1;
          end
          if (holdoff_q[hmc_flit_pkg::HOLDOFF_BIT]) begin
            state_q <= hmc_flit_pkg::GEN_WAIT;
          end
        end
        hmc_flit_pkg::GEN_WAIT: begin
          if (s_axis_tx_tready_i) begin
            state_q <= hmc_flit_pkg::GEN_REQ;
          end
        end
        hmc_flit_pkg::GEN_REQ: begin
          // Ready follows last cycle's TREADY
          req_ready_o <= s_axis_tx_tready_i;
        end
        default: begin
          state_q <= hmc_flit_pkg::GEN_IDLE;
        end
      endcase
    end
  end

  // TX word
  always_ff @(posedge CLK) begin
    s_axis_tx_tdata_o <= {rd_f3.raw, wr_f2.raw, wr_f1.raw, wr_f0.raw};
  end

endmodule

//--- src/hmc_flit_pkg.sv
// ----------------------------------------
// Shared FLIT geometry, HMC command codes and FLIT views
// Referenced by package-scoped names from every engine block
// ----------------------------------------
package hmc_flit_pkg;

  // ----------------------------------------
  // AXI word geometry
  // ----------------------------------------
  localparam int FPW     = 4;
  localparam int FLIT_W  = 128;
  localparam int DWIDTH  = FPW * FLIT_W;
  // Valid, header and tail bits, one per FLIT, FLIT 0 lowest
  localparam int TUSER_W = 3 * FPW;
  localparam int FLG_VALID = 0;
  localparam int FLG_HDR   = FPW;
  localparam int FLG_TAIL  = 2 * FPW;

  // User side widths
  // Address counts 32-byte units
  localparam int ADDR_W     = 27;
  localparam int ADDR_SHIFT = 5;
  localparam int TAG_W      = 9;
  localparam int DATA_W     = 256;

  // ----------------------------------------
  // Request header field positions
  // ----------------------------------------
  localparam int HDR_W    = 64;
  localparam int TAIL_W   = FLIT_W - HDR_W;
  localparam int CMD_LO   = 0;
  localparam int RES_LO   = 6;
  localparam int LNG_LO   = 7;
  localparam int DLN_LO   = 11;
  localparam int TAG_LO   = 15;
  localparam int HADDR_LO = 24;
  localparam int CUB_LO   = 58;
  // 34-bit address as the cube sees it
  localparam int HADDR_W  = CUB_LO - HADDR_LO;

  // Commands and packet lengths in FLITs
  localparam logic [5:0] CMD_P_WR32 = 6'b011001;
  localparam logic [3:0] LEN_P_WR32 = 4'd3;
  localparam logic [5:0] CMD_RD32   = 6'b110001;
  localparam logic [3:0] LEN_RD32   = 4'd1;
  // Posted writes get no response so any tag will do
  localparam logic [TAG_W-1:0] WR_TAG = 9'd1;

  // Start-up wait, 256 cycles after POST_DONE
  localparam int HOLDOFF_W   = 16;
  localparam int HOLDOFF_BIT = 8;

  // Request FSM states
  localparam logic [1:0] GEN_IDLE = 2'd0;
  localparam logic [1:0] GEN_WAIT = 2'd1;
  localparam logic [1:0] GEN_REQ  = 2'd2;

  // RX buffer
  localparam int RX_FIFO_DEPTH = 32;
  localparam int RX_FIFO_PTR_W = $clog2(RX_FIFO_DEPTH);

  typedef struct packed {
    logic [HDR_W-CUB_LO-1:0]     cub;
    logic [HADDR_W-1:0]          addr;
    logic [HADDR_LO-TAG_LO-1:0]  tag;
    logic [TAG_LO-DLN_LO-1:0]    dln;
    logic [DLN_LO-LNG_LO-1:0]    lng;
    logic [LNG_LO-RES_LO-1:0]    res;
    logic [RES_LO-CMD_LO-1:0]    cmd;
  } hdr_t;

  // Same FLIT read as header plus tail or as plain payload
  typedef union packed {
    struct packed {
      logic [TAIL_W-1:0] tail;
      hdr_t              hdr;
    } hv;
    logic [FLIT_W-1:0] raw;
  } flit_t;

endpackage
